// File: compile.f
sm83_irq_pkg.sv
sm83_wb_if.sv
sm83_irq_prio.sv
sm83_irq_regs.sv
sm83_irq_dispatch.sv
sm83_wb_arbiter.sv
sm83_irq_top.sv
tb_sm83_irq.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and judges the log.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_sm83_irq -f compile.f -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status, see sim.log"
	exit 1
fi

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi
echo "simulation passed"
exit 0

// File: sm83_irq_dispatch.sv
`default_nettype none

module sm83_irq_dispatch #(
		parameter int N_IRQ = sm83_irq_pkg::IRQ_MAX
	) (
		input  logic                   clk, arst_n,
		input  logic                   ime, ack_req, any,
		input  logic [N_IRQ-1:0]       grant,
		sm83_wb_if.master              bus,
		output logic                   freeze,
		output logic                   vector_valid,
		output logic                   busy,
		output sm83_irq_pkg::irq_vec_t vector
	);

	import sm83_irq_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		FREEZE,
		CLEAR,
		DONE
	} state_t;

	state_t state;
	state_t state_next;
	logic   accept;
	logic   wait_ack;

	// rst address of the single set bit in g.
	function automatic irq_vec_t encode_vec(input logic [N_IRQ-1:0] g);
		irq_vec_t v;
		v = VEC_BASE;
		for (int i = 0; i < N_IRQ; i++) begin
			if (g[i]) begin
				v = VEC_BASE + irq_vec_t'(i * VEC_STRIDE);
			end
		end
		return v;
	endfunction

	// without a winner the request is dropped.
	assign accept   = ime & ack_req & any;
	assign wait_ack = (state == FREEZE) || (state == CLEAR);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (accept) begin
					state_next = FREEZE;
				end
			end
			FREEZE: begin
				state_next = CLEAR;
			end
			CLEAR: begin
				if (bus.ack) begin
					state_next = DONE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// clear write of the frozen winner, stb drops after ack.
	assign bus.cyc   = wait_ack;
	assign bus.stb   = wait_ack;
	assign bus.we    = 1'b1;
	assign bus.adr   = ADR_IF_CLR;
	assign bus.dat_w = wb_dat_t'(grant);

	assign freeze       = wait_ack;
	assign busy         = state != IDLE;
	// IF bit is already gone when ack arrives.
	assign vector_valid = wait_ack & bus.ack;
	assign vector       = encode_vec(grant);

	a_frozen_winner: assert property (
		@(posedge clk) disable iff (!arst_n)
		state == FREEZE |-> grant != '0
	);

endmodule

`default_nettype wire

// File: sm83_irq_pkg.sv
`default_nettype none

package sm83_irq_pkg;

	// interrupt sources on the SM83: vblank, lcd, timer, serial, joypad.
	localparam int IRQ_MAX = 5;

	typedef logic [7:0] irq_vec_t;
	typedef logic [7:0] wb_adr_t;
	typedef logic [7:0] wb_dat_t;

	// register map.
	localparam wb_adr_t ADR_IF     = 8'h0F;
	localparam wb_adr_t ADR_IE     = 8'hFF;
	// write-one-to-clear alias of IF.
	localparam wb_adr_t ADR_IF_CLR = 8'h10;

	// rst vectors 0x40, 0x48, 0x50, 0x58, 0x60.
	localparam irq_vec_t VEC_BASE   = 8'h40;
	localparam int       VEC_STRIDE = 8;

endpackage

`default_nettype wire

// File: sm83_irq_prio.sv
`default_nettype none

module sm83_irq_prio #(
		parameter int N_IRQ = sm83_irq_pkg::IRQ_MAX
	) (
		input  logic             clk, arst_n,
		input  logic [N_IRQ-1:0] pending,
		input  logic             freeze,
		output logic [N_IRQ-1:0] grant,
		output logic             any
	);

	// higher[i] is high when some slice above i has a request.
	logic [N_IRQ:0]   higher;
	logic [N_IRQ-1:0] grant_c;
	logic [N_IRQ-1:0] grant_q;

	assign higher[0] = 1'b0;

	for (genvar i = 0; i < N_IRQ; i++) begin : g_cell
		assign grant_c[i]  = pending[i] & ~higher[i];
		assign higher[i+1] = higher[i] | pending[i];
	end

	// tracks the chain until freeze rises, then holds that winner.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			grant_q <= '0;
		end else if (!freeze) begin
			grant_q <= grant_c;
		end
	end

	assign grant = freeze ? grant_q : grant_c;
	assign any   = freeze ? |grant_q : higher[N_IRQ];

	a_grant_onehot: assert property (
		@(posedge clk) disable iff (!arst_n)
		$onehot0(grant)
	);

endmodule

`default_nettype wire

// File: sm83_irq_regs.sv
`default_nettype none

module sm83_irq_regs #(
		parameter int N_IRQ = sm83_irq_pkg::IRQ_MAX
	) (
		input  logic             clk, arst_n,
		sm83_wb_if.slave         bus,
		input  logic [N_IRQ-1:0] irq_src,
		output logic [N_IRQ-1:0] pending
	);

	import sm83_irq_pkg::*;

	localparam int DW = $bits(wb_dat_t);

	logic [N_IRQ-1:0] if_q;
	logic [N_IRQ-1:0] ie_q;
	logic [N_IRQ-1:0] if_next;
	logic             access;
	logic             wr_if;
	logic             wr_ie;
	logic             wr_clr;
	wb_dat_t          rd_data;

	// one access per request, the cycle ack is high does not count.
	assign access = bus.cyc & bus.stb & ~bus.ack;
	assign wr_if  = access & bus.we & (bus.adr == ADR_IF);
	assign wr_ie  = access & bus.we & (bus.adr == ADR_IE);
	assign wr_clr = access & bus.we & (bus.adr == ADR_IF_CLR);

	always_comb begin
		if_next = if_q;
		if (wr_if) begin
			if_next = bus.dat_w[N_IRQ-1:0];
		end
		if (wr_clr) begin
			if_next = if_q & ~bus.dat_w[N_IRQ-1:0];
		end
		// sources win over a clear in the same cycle.
		if_next = if_next | irq_src;
	end

	// unused bits read as 1.
	always_comb begin
		case (bus.adr)
			ADR_IF: begin
				rd_data = {{(DW-N_IRQ){1'b1}}, if_q};
			end
			ADR_IE: begin
				rd_data = {{(DW-N_IRQ){1'b1}}, ie_q};
			end
			default: begin
				rd_data = '1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_q    <= '0;
			ie_q    <= '0;
			bus.ack <= 1'b0;
		end else begin
			if_q    <= if_next;
			bus.ack <= access;
			if (wr_ie) begin
				ie_q <= bus.dat_w[N_IRQ-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			bus.dat_r <= rd_data;
		end
	end

	assign pending = if_q & ie_q;

	a_ack_after_stb: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(bus.ack) |-> $past(bus.cyc && bus.stb)
	);

endmodule

`default_nettype wire

// File: sm83_irq_tests.txt
# name op arg0 arg1 expected, all values hex and 00 where unused
# wr adr dat | rd adr - dat | src bits | ime level | ack - - vec | noack | both adr dat vec
ie_reset      rd    FF 00 E0
if_reset      rd    0F 00 E0
ie_write      wr    FF 15 00
ie_read       rd    FF 00 F5
ie_write_all  wr    FF 1F 00
ie_read_all   rd    FF 00 FF
other_addr    rd    33 00 FF
src_raise     src   0B 00 00
if_after_src  rd    0F 00 EB
if_clr        wr    10 0A 00
if_after_clr  rd    0F 00 E1
if_clr_all    wr    10 1F 00
if_empty      rd    0F 00 E0
src_multi     src   1C 00 00
ime_low       ime   00 00 00
ack_ime_low   noack 00 00 00
if_kept       rd    0F 00 FC
ime_on        ime   01 00 00
ack_first     ack   00 00 50
ack_second    ack   00 00 58
src_late      src   01 00 00
ack_late      ack   00 00 40
ack_last      ack   00 00 60
ack_empty     noack 00 00 00
if_drained    rd    0F 00 E0
ie_mask       wr    FF 05 00
ie_masked     rd    FF 00 E5
src_masked    src   0A 00 00
ack_masked    noack 00 00 00
if_masked     rd    0F 00 EA
src_mixed     src   06 00 00
both_first    both  0F EA 50
ack_disabled  noack 00 00 00
if_final      rd    0F 00 EA

// File: sm83_irq_top.sv
`default_nettype none

module sm83_irq_top #(
		parameter int N_IRQ = 5
	) (
		input  logic                   clk, arst_n,
		input  logic                   host_cyc, host_stb, host_we,
		input  sm83_irq_pkg::wb_adr_t  host_adr,
		input  sm83_irq_pkg::wb_dat_t  host_dat_w,
		output sm83_irq_pkg::wb_dat_t  host_dat_r,
		output logic                   host_ack,
		input  logic [N_IRQ-1:0]       irq_src,
		input  logic                   ime, ack_req,
		output logic                   vector_valid,
		output sm83_irq_pkg::irq_vec_t vector,
		output logic                   busy
	);

	logic [N_IRQ-1:0] pending;
	logic [N_IRQ-1:0] grant;
	logic             any;
	logic             freeze;

	sm83_wb_if host_bus ();
	sm83_wb_if disp_bus ();
	sm83_wb_if reg_bus ();

	// host port onto arbiter master 1.
	assign host_bus.cyc   = host_cyc;
	assign host_bus.stb   = host_stb;
	assign host_bus.we    = host_we;
	assign host_bus.adr   = host_adr;
	assign host_bus.dat_w = host_dat_w;
	assign host_dat_r     = host_bus.dat_r;
	assign host_ack       = host_bus.ack;

	sm83_irq_regs #(.N_IRQ(N_IRQ)) regs_i (
		.clk, .arst_n,
		.bus     (reg_bus.slave),
		.irq_src,
		.pending
	);

	sm83_irq_prio #(.N_IRQ(N_IRQ)) prio_i (
		.clk, .arst_n,
		.pending,
		.freeze,
		.grant,
		.any
	);

	sm83_irq_dispatch #(.N_IRQ(N_IRQ)) dispatch_i (
		.clk, .arst_n,
		.ime, .ack_req, .any,
		.grant,
		.bus          (disp_bus.master),
		.freeze,
		.vector_valid,
		.busy,
		.vector
	);

	// dispatch has the higher priority.
	sm83_wb_arbiter arbiter_i (
		.clk, .arst_n,
		.m0 (disp_bus.slave),
		.m1 (host_bus.slave),
		.s  (reg_bus.master)
	);

endmodule

`default_nettype wire

// File: sm83_wb_arbiter.sv
`default_nettype none

module sm83_wb_arbiter (
		input  logic       clk, arst_n,
		sm83_wb_if.slave   m0,
		sm83_wb_if.slave   m1,
		sm83_wb_if.master  s
	);

	logic owner_valid;
	// 0 is m0, 1 is m1.
	logic owner_sel;
	logic own_cyc;

	assign own_cyc = owner_sel ? m1.cyc : m0.cyc;

	// m0 first. the owner keeps the bus while its cyc is high.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			owner_valid <= 1'b0;
			owner_sel   <= 1'b0;
		end else if (!owner_valid || !own_cyc) begin
			if (m0.cyc) begin
				owner_valid <= 1'b1;
				owner_sel   <= 1'b0;
			end else if (m1.cyc) begin
				owner_valid <= 1'b1;
				owner_sel   <= 1'b1;
			end else begin
				owner_valid <= 1'b0;
			end
		end
	end

	assign s.cyc   = owner_valid & own_cyc;
	assign s.stb   = owner_valid & (owner_sel ? m1.stb : m0.stb);
	assign s.we    = owner_sel ? m1.we    : m0.we;
	assign s.adr   = owner_sel ? m1.adr   : m0.adr;
	assign s.dat_w = owner_sel ? m1.dat_w : m0.dat_w;

	// return path goes to the owner only.
	assign m0.ack   = s.ack & owner_valid & ~owner_sel;
	assign m1.ack   = s.ack & owner_valid & owner_sel;
	assign m0.dat_r = owner_sel ? '0 : s.dat_r;
	assign m1.dat_r = owner_sel ? s.dat_r : '0;

	a_cyc_owned: assert property (
		@(posedge clk) disable iff (!arst_n)
		s.cyc |-> owner_valid
	);

	// slave ack answers a strobe the same owner issued a cycle earlier.
	a_ack_owned: assert property (
		@(posedge clk) disable iff (!arst_n)
		s.ack |-> owner_valid && $past(s.stb) && $stable(owner_sel)
	);

endmodule

`default_nettype wire

// File: sm83_wb_if.sv
`default_nettype none

interface sm83_wb_if;

	import sm83_irq_pkg::*;

	logic    cyc;
	logic    stb;
	logic    we;
	wb_adr_t adr;
	wb_dat_t dat_w;
	wb_dat_t dat_r;
	logic    ack;

	// request fields stay put until ack is seen.
	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

`default_nettype wire

// File: tb_sm83_irq.sv
`default_nettype none

module tb_sm83_irq;

	import sm83_irq_pkg::*;

	localparam int N_IRQ    = 5;
	localparam int ACK_WAIT = 16;
	localparam int BUS_WAIT = 32;

	logic             clk, arst_n;
	logic             host_cyc, host_stb, host_we;
	wb_adr_t          host_adr;
	wb_dat_t          host_dat_w, host_dat_r;
	logic             host_ack;
	logic [N_IRQ-1:0] irq_src;
	logic             ime, ack_req, vector_valid, busy;
	irq_vec_t         vector;

	string   t_name[$];
	string   t_op[$];
	wb_dat_t t_a0[$];
	wb_dat_t t_a1[$];
	wb_dat_t t_exp[$];
	int      n_tests = 0;
	int      n_fail;
	int      load_err;
	int      test_err;

	sm83_irq_top #(.N_IRQ(N_IRQ)) sm83_irq_top_i (
		.clk, .arst_n, .host_cyc, .host_stb, .host_we, .host_adr, .host_dat_w,
		.host_dat_r, .host_ack, .irq_src, .ime, .ack_req, .vector_valid, .vector, .busy
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// inputs change 1 unit after the rising edge.
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %02h actual %02h", name, exp, act);
			test_err++;
		end
	endtask

	task automatic check_vec(input string name, input irq_vec_t exp, input irq_vec_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %02h actual %02h", name, exp, act);
			test_err++;
		end
	endtask

	task automatic host_access(input string name, input logic we, input wb_adr_t adr,
			input wb_dat_t dat, output wb_dat_t rdat);
		int   n;
		logic done;
		n = 0;
		done = 1'b0;
		rdat = '0;
		host_cyc = 1'b1;
		host_stb = 1'b1;
		host_we = we;
		host_adr = adr;
		host_dat_w = dat;
		while (!done && n < BUS_WAIT) begin
			next_cycle();
			n++;
			if (host_ack) begin
				done = 1'b1;
				rdat = host_dat_r;
			end
		end
		host_cyc = 1'b0;
		host_stb = 1'b0;
		if (!done) begin
			$display("%s: host access to %02h got no ack", name, adr);
			test_err++;
		end
	endtask

	// ack_req is a one-cycle pulse.
	task automatic acknowledge(output irq_vec_t vec, output logic seen, output logic was_busy);
		int n;
		n = 0;
		seen = 1'b0;
		was_busy = 1'b0;
		vec = '0;
		ack_req = 1'b1;
		while (!seen && n < ACK_WAIT) begin
			next_cycle();
			ack_req = 1'b0;
			n++;
			if (busy) begin
				was_busy = 1'b1;
			end
			if (vector_valid) begin
				seen = 1'b1;
				vec = vector;
			end
		end
	endtask

	task automatic run_test(input int k);
		wb_dat_t  rdat;
		irq_vec_t vec;
		logic     seen;
		logic     was_busy;
		string    name;
		int       n;
		name = t_name[k];
		test_err = 0;
		n = 0;
		case (t_op[k])
			"wr": host_access(name, 1'b1, t_a0[k], t_a1[k], rdat);
			"rd": begin
				host_access(name, 1'b0, t_a0[k], 8'h00, rdat);
				check_dat(name, t_exp[k], rdat);
			end
			"src": begin
				irq_src = t_a0[k][N_IRQ-1:0];
				next_cycle();
				irq_src = '0;
			end
			"ime": begin
				ime = t_a0[k][0];
				next_cycle();
			end
			"ack", "noack": acknowledge(vec, seen, was_busy);
			"both": begin
				// host read starts while dispatch already holds the bus.
				fork
					acknowledge(vec, seen, was_busy);
					begin
						next_cycle();
						host_access(name, 1'b0, t_a0[k], 8'h00, rdat);
					end
				join
				check_dat(name, t_a1[k], rdat);
			end
			default: begin
				$display("%s: unknown operation %s", name, t_op[k]);
				test_err++;
			end
		endcase
		if (t_op[k] == "ack" || t_op[k] == "both") begin
			if (seen) begin
				check_vec(name, t_exp[k], vec);
			end else begin
				$display("%s: no vector_valid within %0d cycles", name, ACK_WAIT);
				test_err++;
			end
			if (!was_busy) begin
				$display("%s: busy stayed low during the dispatch", name);
				test_err++;
			end
		end
		if (t_op[k] == "noack") begin
			if (seen) begin
				$display("%s: vector_valid raised with no dispatch due", name);
				test_err++;
			end
			if (was_busy) begin
				$display("%s: busy raised with no dispatch due", name);
				test_err++;
			end
		end
		while (busy && n < ACK_WAIT) begin
			next_cycle();
			n++;
		end
		if (busy) begin
			$display("%s: dispatch still busy after %0d cycles", name, ACK_WAIT);
			test_err++;
		end
		if (test_err == 0) begin
			$display("%s %s: ok", name, t_op[k]);
		end else begin
			$display("%s %s: error", name, t_op[k]);
			n_fail++;
		end
	endtask

	initial begin
		wait (n_tests > 0);
		repeat (n_tests * 64) @(posedge clk);
		$display("watchdog expired after %0d cycles", n_tests * 64);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int      fd;
		string   line;
		string   name;
		string   op;
		wb_dat_t a0, a1, ex;
		arst_n = 1'b0;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_dat_w = '0;
		irq_src = '0;
		ime = 1'b0;
		ack_req = 1'b0;
		n_fail = 0;
		load_err = 0;
		fd = $fopen("sm83_irq_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open sm83_irq_tests.txt");
			load_err++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) > 1 && line[0] != "#") begin
					if ($sscanf(line, "%s %s %h %h %h", name, op, a0, a1, ex) == 5) begin
						t_name.push_back(name);
						t_op.push_back(op);
						t_a0.push_back(a0);
						t_a1.push_back(a1);
						t_exp.push_back(ex);
					end else begin
						$display("malformed line in test file: %s", line);
						load_err++;
					end
				end
			end
			$fclose(fd);
		end
		if (t_name.size() == 0) begin
			$display("no tests found");
			load_err++;
		end
		n_tests = t_name.size();
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		next_cycle();
		for (int k = 0; k < n_tests; k++) begin
			run_test(k);
		end
		$display("%0d tests, %0d passed, %0d failed", n_tests, n_tests - n_fail, n_fail);
		if (n_fail == 0 && load_err == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
